/* rtl/fu_config.svh */
////////////////////////////////////////
// Widths for the FU datapath and counters
// FU_DIV_CNT_WIDTH must hold FU_DATA_WIDTH
////////////////////////////////////////

`ifndef FU_CONFIG_SVH
`define FU_CONFIG_SVH

// Operand and result width
`define FU_DATA_WIDTH 32
// Accumulation counter and target width
`define FU_ACC_CNT_WIDTH 16
// Divider step counter width
`define FU_DIV_CNT_WIDTH 6

`endif

/* rtl/fu_pkg.sv */
////////////////////////////////////////
// FU opcodes and operand/result bundles
////////////////////////////////////////

`include "fu_config.svh"

package fu_pkg;

  // FU opcode, 5 bits to match the PE instruction field
  typedef enum logic [4:0] {
    NOP,
    ADD,
    SUB,
    MUL,
    LSH,
    ARSH,
    LRSH,
    MIN,
    MAX,
    ABS,
    ACC,
    DIV,
    REM
  } fu_op_e;

  // Operand pair from the PE input muxes
  typedef struct packed {
    logic [`FU_DATA_WIDTH-1:0] a;
    logic [`FU_DATA_WIDTH-1:0] b;
  } fu_operands_t;

  // Main result plus second half of a division
  typedef struct packed {
    logic [`FU_DATA_WIDTH-1:0] res;
    logic [`FU_DATA_WIDTH-1:0] rem_q;
  } fu_result_t;

endpackage

/* rtl/fu_alu.sv */
////////////////////////////////////////
// Single-cycle datapath, no DIV/REM here
// Shift amount uses low log2(width) bits of b
////////////////////////////////////////

`timescale 1ns/1ps

`include "fu_config.svh"

module fu_alu
  import fu_pkg::*;
(
  input  fu_op_e                    instr_i,
  input  fu_operands_t              ops_i,
  output logic [`FU_DATA_WIDTH-1:0] res_o
);

  localparam int W = `FU_DATA_WIDTH;
  localparam int SHW = $clog2(W);

  // Shared adder, bit 0 carries the +1 for subtraction
  logic [W:0]     add_op1;
  logic [W:0]     add_op2;
  logic [W:0]     add_res;
  logic [W-1:0]   sum;
  logic [W-1:0]   mul_res;
  logic [W-1:0]   a_rev;
  logic [2*W-1:0] shift_op;
  logic [2*W-1:0] shift_ext;
  logic [W-1:0]   shift_res;
  logic [W-1:0]   lsh_res;
  logic [SHW-1:0] shamt;
  logic           a_lt_b;

  ////////////////////////////////////////
  // Adder operand select
  ////////////////////////////////////////
  always_comb begin
    add_op1 = {ops_i.a, 1'b0};
    add_op2 = {ops_i.b, 1'b0};
    case (instr_i)
      // a - b as a + ~b + 1
      SUB, MIN, MAX: begin
        add_op1 = {ops_i.a, 1'b1};
        add_op2 = {~ops_i.b, 1'b1};
      end
      // -a as ~a + 1
      ABS: begin
        add_op1 = {~ops_i.a, 1'b1};
        add_op2 = {{W{1'b0}}, 1'b1};
      end
      default: ;
    endcase
  end

  assign add_res = add_op1 + add_op2;
  // Drop the carry-in slot
  assign sum = add_res[W:1];

  // Low half of the product only
  assign mul_res = ops_i.a * ops_i.b;

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////
  assign shamt = ops_i.b[SHW-1:0];

  // Left shift = reversed right shift
  always_comb begin
    for (int i = 0; i < W; i++) begin
      a_rev[i] = ops_i.a[W-1-i];
    end
  end

  always_comb begin
    case (instr_i)
      LRSH:    shift_op = {{W{1'b0}}, ops_i.a};
      LSH:     shift_op = {{W{1'b0}}, a_rev};
      default: shift_op = {{W{ops_i.a[W-1]}}, ops_i.a};
    endcase
  end

  assign shift_ext = $signed(shift_op) >>> shamt;
  assign shift_res = shift_ext[W-1:0];

  // Undo the reversal
  always_comb begin
    for (int i = 0; i < W; i++) begin
      lsh_res[i] = shift_res[W-1-i];
    end
  end

  // Signed a < b; differing signs decide alone, else sign of a - b
  assign a_lt_b = (ops_i.a[W-1] != ops_i.b[W-1]) ? ops_i.a[W-1] : sum[W-1];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////
  always_comb begin
    case (instr_i)
      ADD, SUB, ACC: res_o = sum;
      MUL:           res_o = mul_res;
      LSH:           res_o = lsh_res;
      ARSH, LRSH:    res_o = shift_res;
      MIN:           res_o = a_lt_b ? ops_i.a : ops_i.b;
      MAX:           res_o = a_lt_b ? ops_i.b : ops_i.a;
      ABS:           res_o = ops_i.a[W-1] ? sum : ops_i.a;
      default:       res_o = '0;
    endcase
  end

endmodule

/* rtl/fu_acc_ctrl.sv */
////////////////////////////////////////
// Target must stay stable while ACC/MAX runs
////////////////////////////////////////

`timescale 1ns/1ps

`include "fu_config.svh"

module fu_acc_ctrl
  import fu_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         acc_op_i,
  input  logic                         ops_valid_i,
  input  logic                         pea_ready_i,
  input  logic [`FU_ACC_CNT_WIDTH-1:0] acc_target_i,
  output logic                         acc_valid_o,
  output logic                         acc_loopback_o
);

  logic [`FU_ACC_CNT_WIDTH-1:0] acc_cnt;
  logic                         accept;
  logic                         at_target;

  // Operand taken only when array can move
  assign accept    = ops_valid_i && pea_ready_i;
  assign at_target = (acc_cnt == acc_target_i);

  // Count accepted operands, clear on last or on any other opcode
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_cnt        <= '0;
      acc_loopback_o <= 1'b0;
    end else if (!acc_op_i) begin
      acc_cnt        <= '0;
      acc_loopback_o <= 1'b0;
    end else if (accept && at_target) begin
      acc_cnt        <= '0;
      acc_loopback_o <= 1'b0;
    end else if (accept) begin
      acc_cnt        <= acc_cnt + 1'b1;
      acc_loopback_o <= 1'b1;
    end
  end

  // Final operand present
  assign acc_valid_o = at_target && ops_valid_i;

  a_cnt_bounded : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_op_i |-> (acc_cnt <= acc_target_i));

endmodule

/* rtl/fu_serial_divider.sv */
////////////////////////////////////////
// Radix-2 restoring with done FU_DATA_WIDTH+1 cycles after start
// start_i only while ready_o and result held until next start
////////////////////////////////////////

`timescale 1ns/1ps

`include "fu_config.svh"

module fu_serial_divider
  import fu_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         start_i,
  input  fu_operands_t ops_i,
  output logic         ready_o,
  output logic         done_o,
  output fu_result_t   result_o
);

  localparam int W = `FU_DATA_WIDTH;
  localparam int CW = `FU_DIV_CNT_WIDTH;
  localparam logic [CW-1:0] LAST_STEP = CW'(W);

  // Control
  logic          busy_q;
  logic          done_q;
  logic [CW-1:0] step_q;

  // Datapath holds magnitudes until the final fix
  logic [W-1:0]  part_rem_q;
  logic [W-1:0]  quot_q;
  logic [W-1:0]  divisor_q;
  logic          neg_quot_q;
  logic          neg_rem_q;
  logic          div_zero_q;
  fu_result_t    result_q;

  logic [W-1:0]  a_abs;
  logic [W-1:0]  b_abs;
  logic [W:0]    shifted;
  logic [W:0]    trial;

  assign a_abs = ops_i.a[W-1] ? (~ops_i.a + 1'b1) : ops_i.a;
  assign b_abs = ops_i.b[W-1] ? (~ops_i.b + 1'b1) : ops_i.b;

  // Bring down next dividend bit and try subtract
  assign shifted = {part_rem_q, quot_q[W-1]};
  assign trial   = shifted - {1'b0, divisor_q};

  ////////////////////////////////////////
  // Step sequencing
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        // Extra cycle after last step for sign fix
        if (step_q == LAST_STEP) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          step_q <= step_q + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Restoring datapath
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      part_rem_q <= '0;
      quot_q     <= a_abs;
      divisor_q  <= b_abs;
      neg_quot_q <= ops_i.a[W-1] ^ ops_i.b[W-1];
      neg_rem_q  <= ops_i.a[W-1];
      div_zero_q <= (ops_i.b == '0);
    end else if (busy_q && step_q != LAST_STEP) begin
      // Negative trial means restore
      if (trial[W]) begin
        part_rem_q <= shifted[W-1:0];
        quot_q     <= {quot_q[W-2:0], 1'b0};
      end else begin
        part_rem_q <= trial[W-1:0];
        quot_q     <= {quot_q[W-2:0], 1'b1};
      end
    end else if (busy_q) begin
      // Truncate toward zero with remainder sign from dividend
      result_q.res   <= div_zero_q ? '1 : (neg_quot_q ? (~quot_q + 1'b1) : quot_q);
      result_q.rem_q <= neg_rem_q ? (~part_rem_q + 1'b1) : part_rem_q;
    end
  end

  assign ready_o  = !busy_q;
  assign done_o   = done_q;
  assign result_o = result_q;

  // Launch logic in the top must honour ready_o
  a_no_start_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> !busy_q);

  // Fixed latency and a one-cycle done pulse
  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> ##(W+2) done_q ##1 !done_q);

endmodule

/* rtl/fu_top.sv */
////////////////////////////////////////
// Strobe/level interface, no handshake
// DIV/REM launch only while divider ready_o
////////////////////////////////////////

`timescale 1ns/1ps

`include "fu_config.svh"

module fu_top
  import fu_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  fu_op_e                       instr_i,
  input  fu_operands_t                 ops_i,
  input  logic                         ops_valid_i,
  input  logic                         pea_ready_i,
  input  logic [`FU_ACC_CNT_WIDTH-1:0] acc_target_i,
  output logic                         valid_o,
  output logic                         ready_o,
  output logic                         acc_loopback_o,
  output fu_result_t                   result_o
);

  // Instruction class
  logic                      acc_op;
  logic                      div_op;
  // Sub-unit returns
  logic [`FU_DATA_WIDTH-1:0] alu_res;
  logic                      acc_valid;
  logic                      div_start;
  logic                      div_ready;
  logic                      div_done;
  fu_result_t                div_result;

  // Everything else is single cycle
  assign acc_op = (instr_i == ACC) || (instr_i == MAX);
  assign div_op = (instr_i == DIV) || (instr_i == REM);

  assign div_start = ops_valid_i && div_op && div_ready;

  fu_alu u_alu (
    .instr_i (instr_i),
    .ops_i   (ops_i),
    .res_o   (alu_res)
  );

  fu_acc_ctrl u_acc_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .acc_op_i       (acc_op),
    .ops_valid_i    (ops_valid_i),
    .pea_ready_i    (pea_ready_i),
    .acc_target_i   (acc_target_i),
    .acc_valid_o    (acc_valid),
    .acc_loopback_o (acc_loopback_o)
  );

  fu_serial_divider u_divider (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (div_start),
    .ops_i    (ops_i),
    .ready_o  (div_ready),
    .done_o   (div_done),
    .result_o (div_result)
  );

  ////////////////////////////////////////
  // Valid, ready and result select
  ////////////////////////////////////////
  always_comb begin
    valid_o        = ops_valid_i;
    ready_o        = 1'b1;
    result_o.res   = alu_res;
    result_o.rem_q = '0;
    if (div_op) begin
      valid_o = div_done;
      ready_o = div_ready;
      // REM returns remainder first, quotient second
      if (instr_i == REM) begin
        result_o.res   = div_result.rem_q;
        result_o.rem_q = div_result.res;
      end else begin
        result_o = div_result;
      end
    end else if (acc_op) begin
      valid_o = acc_valid;
    end
  end

endmodule

/* testbench/tb_fu_top.sv */
////////////////////////////////////////
// Directed self-checking tests for fu_top
// Inputs change on the falling edge and outputs are read 1 ns later
////////////////////////////////////////

`timescale 1ns/1ps

`include "fu_config.svh"

module tb_fu_top
  import fu_pkg::*;
();

  localparam int W = `FU_DATA_WIDTH;
  localparam int CW = `FU_ACC_CNT_WIDTH;
  // Margin well above the W+1 cycle divider latency
  localparam int DIV_TIMEOUT = 3 * W;

  logic            clk_i;
  logic            rst_n_i;
  fu_op_e          instr_i;
  fu_operands_t    ops_i;
  logic            ops_valid_i;
  logic            pea_ready_i;
  logic [CW-1:0]   acc_target_i;
  logic            valid_o;
  logic            ready_o;
  logic            acc_loopback_o;
  fu_result_t      result_o;

  // Bookkeeping
  int error_count;
  int check_count;
  int test_count;
  int test_fail_count;
  int errors_at_start;

  fu_top DUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_i        (instr_i),
    .ops_i          (ops_i),
    .ops_valid_i    (ops_valid_i),
    .pea_ready_i    (pea_ready_i),
    .acc_target_i   (acc_target_i),
    .valid_o        (valid_o),
    .ready_o        (ready_o),
    .acc_loopback_o (acc_loopback_o),
    .result_o       (result_o)
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////
  function automatic logic [W-1:0] alu_model(input fu_op_e op, input logic [W-1:0] a,
                                             input logic [W-1:0] b);
    case (op)
      ADD, ACC: return a + b;
      SUB:      return a - b;
      MUL:      return a * b;
      LSH:      return a << b[4:0];
      ARSH:     return $signed(a) >>> b[4:0];
      LRSH:     return a >> b[4:0];
      MIN:      return ($signed(a) < $signed(b)) ? a : b;
      MAX:      return ($signed(a) < $signed(b)) ? b : a;
      // Most negative value stays as is
      ABS:      return a[W-1] ? -a : a;
      default:  return '0;
    endcase
  endfunction

  // Truncating division with remainder sign from dividend
  function automatic fu_result_t div_model(input fu_op_e op, input logic [W-1:0] a,
                                           input logic [W-1:0] b);
    longint     sa;
    longint     sb;
    logic [W-1:0] q;
    logic [W-1:0] r;
    fu_result_t exp;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (b == '0) begin
      q = '1;
      r = a;
    end else begin
      q = W'(sa / sb);
      r = W'(sa % sb);
    end
    // REM swaps the halves
    exp.res   = (op == REM) ? r : q;
    exp.rem_q = (op == REM) ? q : r;
    return exp;
  endfunction

  ////////////////////////////////////////
  // Compare and drive helpers
  ////////////////////////////////////////
  task automatic check_result(input string name, input fu_result_t got, input fu_result_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic begin_test();
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic report_test(input string name);
    if (error_count == errors_at_start) begin
      $display("test %-12s ok", name);
    end else begin
      test_fail_count++;
      $display("test %-12s failed with %0d errors", name, error_count - errors_at_start);
    end
  endtask

  // New inputs on the falling edge and 1 ns settle before sampling
  task automatic apply(input fu_op_e op, input logic [W-1:0] a, input logic [W-1:0] b,
                       input logic valid, input logic ready);
    @(negedge clk_i);
    instr_i     = op;
    ops_i.a     = a;
    ops_i.b     = b;
    ops_valid_i = valid;
    pea_ready_i = ready;
    #1;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic reset_state();
    begin_test();
    apply(NOP, '0, '0, 1'b0, 1'b1);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("acc_loopback_o", acc_loopback_o, 1'b0);
    report_test("reset");
  endtask

  task automatic one_cycle_ops();
    fu_op_e       op_list [8];
    fu_result_t   exp;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic         v;
    op_list = '{ADD, SUB, MUL, LSH, ARSH, LRSH, MIN, ABS};
    begin_test();
    foreach (op_list[i]) begin
      for (int n = 0; n < 6; n++) begin
        a = $urandom;
        b = $urandom;
        // Every third cycle without a strobe
        v = (n % 3) != 2;
        apply(op_list[i], a, b, v, 1'b1);
        exp.res   = alu_model(op_list[i], a, b);
        exp.rem_q = '0;
        check_bit("valid_o", valid_o, v);
        check_bit("ready_o", ready_o, 1'b1);
        check_result($sformatf("result_o (%s)", op_list[i].name()), result_o, exp);
      end
    end
    report_test("one_cycle");
  endtask

  // Previous sum fed back on b like the PE loopback
  task automatic acc_run();
    fu_result_t   exp;
    logic [W-1:0] a;
    logic [W-1:0] sum;
    int           k;
    k = 3;
    begin_test();
    apply(NOP, '0, '0, 1'b0, 1'b1);
    @(negedge clk_i);
    acc_target_i = CW'(k);
    sum = '0;
    for (int n = 1; n <= k + 1; n++) begin
      a = $urandom;
      apply(ACC, a, sum, 1'b1, 1'b1);
      sum = sum + a;
      exp.res   = sum;
      exp.rem_q = '0;
      check_bit("valid_o", valid_o, n == k + 1);
      check_bit("acc_loopback_o", acc_loopback_o, n > 1);
      check_result("result_o (ACC)", result_o, exp);
    end
    // Last operand closes the run
    apply(NOP, '0, '0, 1'b0, 1'b1);
    check_bit("acc_loopback_o", acc_loopback_o, 1'b0);
    report_test("acc");
  endtask

  task automatic max_run();
    fu_result_t   exp;
    logic [W-1:0] a;
    logic [W-1:0] best;
    int           k;
    k = 4;
    begin_test();
    apply(NOP, '0, '0, 1'b0, 1'b1);
    @(negedge clk_i);
    acc_target_i = CW'(k);
    best = {1'b1, {(W-1){1'b0}}};
    for (int n = 1; n <= k + 1; n++) begin
      a = $urandom;
      // Stalled cycle holds the count
      if (n == 3) begin
        apply(MAX, a, best, 1'b1, 1'b0);
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("acc_loopback_o", acc_loopback_o, 1'b1);
      end
      apply(MAX, a, best, 1'b1, 1'b1);
      best = alu_model(MAX, a, best);
      exp.res   = best;
      exp.rem_q = '0;
      check_bit("valid_o", valid_o, n == k + 1);
      check_result("result_o (MAX)", result_o, exp);
    end
    apply(NOP, '0, '0, 1'b0, 1'b1);
    report_test("max");
  endtask

  // One division from start strobe to valid pulse
  task automatic run_div(input fu_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
    int waited;
    apply(op, a, b, 1'b1, 1'b1);
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("valid_o", valid_o, 1'b0);
    // Divider runs on with strobe low and array stalled
    apply(op, a, b, 1'b0, 1'b0);
    check_bit("ready_o", ready_o, 1'b0);
    waited = 0;
    while (!valid_o && waited < DIV_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!valid_o) begin
      error_count++;
      $display("divider gave no valid within %0d cycles for %s a=%h b=%h",
               DIV_TIMEOUT, op.name(), a, b);
    end else begin
      check_bit("ready_o", ready_o, 1'b1);
      check_result($sformatf("result_o (%s)", op.name()), result_o, div_model(op, a, b));
    end
  endtask

  task automatic div_random();
    logic [W-1:0] a;
    logic [W-1:0] b;
    begin_test();
    run_div(DIV, -W'(7), W'(2));
    run_div(REM, -W'(7), W'(2));
    for (int n = 0; n < 8; n++) begin
      a = $urandom;
      b = $urandom;
      // Spread divisor magnitudes
      b = $signed(b) >>> ($urandom % 31);
      if (b == '0) begin
        b = W'(3);
      end
      run_div((n % 2) ? REM : DIV, a, b);
    end
    report_test("div_rem");
  endtask

  task automatic div_corners();
    logic [W-1:0] min_neg;
    min_neg = {1'b1, {(W-1){1'b0}}};
    begin_test();
    run_div(DIV, W'(1234), '0);
    run_div(REM, -W'(99), '0);
    // Quotient wraps back to the dividend
    run_div(DIV, min_neg, '1);
    run_div(REM, min_neg, '1);
    report_test("div_corner");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(32'hec6a_92ef));
    error_count     = 0;
    check_count     = 0;
    test_count      = 0;
    test_fail_count = 0;
    rst_n_i      = 1'b0;
    instr_i      = NOP;
    ops_i        = '0;
    ops_valid_i  = 1'b0;
    pea_ready_i  = 1'b1;
    acc_target_i = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    reset_state();
    one_cycle_ops();
    acc_run();
    max_run();
    div_random();
    div_corners();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, test_fail_count, check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+rtl
rtl/fu_pkg.sv
rtl/fu_alu.sv
rtl/fu_acc_ctrl.sv
rtl/fu_serial_divider.sv
rtl/fu_top.sv
testbench/tb_fu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build tb_fu_top with Verilator, run it, and decide from sim.log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_fu_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_fu_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
